//--- design/rv_exec_pkg.sv
// shared word types, opcode/alu/class/size enums and ISA field constants
`default_nettype none

package rv_exec_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'h03,
        OPC_MISC_MEM  = 7'h0f,
        OPC_OP_IMM    = 7'h13,
        OPC_AUIPC     = 7'h17,
        OPC_OP_IMM_32 = 7'h1b,
        OPC_STORE     = 7'h23,
        OPC_OP        = 7'h33,
        OPC_LUI       = 7'h37,
        OPC_OP_32     = 7'h3b,
        OPC_BRANCH    = 7'h63,
        OPC_JALR      = 7'h67,
        OPC_JAL       = 7'h6f,
        OPC_SYSTEM    = 7'h73
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_LOAD, CLS_STORE, CLS_SYSTEM, CLS_NOP
    } inst_class_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_DOUBLE
    } mem_size_e;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [31:0] INST_ECALL = 32'h0000_0073;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
// instruction decoder: fields, immediates, class and alu operation
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import rv_exec_pkg::*; (
    input  logic [31:0] i_inst,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output xlen_t       o_imm,
    output inst_class_e o_class,
    output alu_op_e     o_alu_op,
    output logic        o_word_op,
    output logic        o_use_imm,
    output logic        o_use_pc,    // pc-relative: AUIPC, JAL
    output logic [2:0]  o_funct3,
    output mem_size_e   o_mem_size,
    output logic        o_mem_unsigned,
    output logic        o_is_ecall
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    xlen_t       imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e     arith_op;
    logic        alt_ok, reg_ok, sh64_ok, sh32_ok, word_f3_ok;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
    assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    // legal funct7 / shamt combinations
    assign alt_ok     = (funct3 == 3'd0) || (funct3 == 3'd5);
    assign reg_ok     = (funct7 == F7_BASE) || (funct7 == F7_ALT && alt_ok);
    assign sh64_ok    = (i_inst[31:26] == 6'b0) || (i_inst[31:26] == 6'b010000 && funct3 == 3'd5);
    assign sh32_ok    = (funct7 == F7_BASE) || (funct7 == F7_ALT && funct3 == 3'd5);
    assign word_f3_ok = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd5);

    always_comb begin
        case (funct3)
            3'd0:    arith_op = i_inst[30] ? ALU_SUB : ALU_ADD;
            3'd1:    arith_op = ALU_SLL;
            3'd2:    arith_op = ALU_SLT;
            3'd3:    arith_op = ALU_SLTU;
            3'd4:    arith_op = ALU_XOR;
            3'd5:    arith_op = i_inst[30] ? ALU_SRA : ALU_SRL;
            3'd6:    arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_class    = CLS_NOP;
        o_alu_op   = ALU_ADD;
        o_word_op  = 1'b0;
        o_use_imm  = 1'b0;
        o_use_pc   = 1'b0;
        o_imm      = '0;
        o_is_ecall = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_alu_op = arith_op;
                o_class  = reg_ok ? CLS_ALU : CLS_NOP; // MUL/DIV land here as nop
            end
            OPC_OP_32: begin
                o_alu_op  = arith_op;
                o_word_op = 1'b1;
                o_class   = (reg_ok && word_f3_ok) ? CLS_ALU : CLS_NOP;
            end
            OPC_OP_IMM: begin
                o_alu_op  = (funct3 == 3'd0) ? ALU_ADD : arith_op; // no SUBI
                o_use_imm = 1'b1;
                o_imm     = imm_i;
                o_class   = (funct3 == 3'd1 || funct3 == 3'd5) && !sh64_ok ? CLS_NOP : CLS_ALU;
            end
            OPC_OP_IMM_32: begin
                o_alu_op  = (funct3 == 3'd0) ? ALU_ADD : arith_op;
                o_word_op = 1'b1;
                o_use_imm = 1'b1;
                o_imm     = imm_i;
                if (funct3 == 3'd0 || (word_f3_ok && sh32_ok)) begin
                    o_class = CLS_ALU;
                end
            end
            OPC_LUI: begin
                o_alu_op  = ALU_PASS_B;
                o_use_imm = 1'b1;
                o_imm     = imm_u;
                o_class   = CLS_ALU;
            end
            OPC_AUIPC: begin
                o_use_imm = 1'b1;
                o_use_pc  = 1'b1;
                o_imm     = imm_u;
                o_class   = CLS_ALU;
            end
            OPC_JAL: begin
                o_use_pc = 1'b1;
                o_imm    = imm_j;
                o_class  = CLS_JUMP;
            end
            OPC_JALR: begin
                o_imm   = imm_i;
                o_class = (funct3 == 3'd0) ? CLS_JUMP : CLS_NOP;
            end
            OPC_BRANCH: begin
                o_imm   = imm_b;
                o_class = (funct3 == 3'd2 || funct3 == 3'd3) ? CLS_NOP : CLS_BRANCH;
            end
            OPC_LOAD: begin
                o_use_imm = 1'b1;
                o_imm     = imm_i;
                o_class   = (funct3 == 3'd7) ? CLS_NOP : CLS_LOAD;
            end
            OPC_STORE: begin
                o_use_imm = 1'b1;
                o_imm     = imm_s;
                o_class   = funct3[2] ? CLS_NOP : CLS_STORE;
            end
            OPC_SYSTEM: begin
                if (i_inst == INST_ECALL) begin
                    o_class    = CLS_SYSTEM;
                    o_is_ecall = 1'b1;
                end
            end
            default: ; // FENCE and unknown opcodes retire as nop
        endcase
    end

    assign o_rs1          = i_inst[19:15];
    assign o_rs2          = i_inst[24:20];
    assign o_rd           = (o_class == CLS_NOP) ? '0 : i_inst[11:7];
    assign o_funct3       = funct3;
    assign o_mem_size     = mem_size_e'(funct3[1:0]);
    assign o_mem_unsigned = funct3[2];

endmodule

`default_nettype wire

//--- design/reg_file.sv
// integer register file, 32 x 64 bit, two async read ports
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_exec_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  logic     i_wr_en,
    input  reg_idx_t i_wr_idx,
    input  xlen_t    i_wr_data,
    output xlen_t    o_rs1_value,
    output xlen_t    o_rs2_value
);

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0) begin // x0 stays zero
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_rs1_value = regs[i_rs1];
    assign o_rs2_value = regs[i_rs2];

endmodule

`default_nettype wire

//--- design/int_alu.sv
// 64-bit integer alu with word-form variants
`timescale 1ns/1ns
`default_nettype none

module int_alu import rv_exec_pkg::*; (
    input  alu_op_e i_op,
    input  logic    i_word_op,
    input  xlen_t   i_a,
    input  xlen_t   i_b,
    output xlen_t   o_result
);

    logic [5:0] shamt;
    xlen_t      a_srl, a_sra, res;

    assign shamt = i_word_op ? {1'b0, i_b[4:0]} : i_b[5:0];

    // word shifts only see the low half
    assign a_srl = i_word_op ? {32'b0, i_a[31:0]} : i_a;
    assign a_sra = i_word_op ? {{32{i_a[31]}}, i_a[31:0]} : i_a;

    always_comb begin
        case (i_op)
            ALU_ADD:    res = i_a + i_b;
            ALU_SUB:    res = i_a - i_b;
            ALU_SLL:    res = i_a << shamt;
            ALU_SLT:    res = {63'b0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:   res = {63'b0, i_a < i_b};
            ALU_XOR:    res = i_a ^ i_b;
            ALU_SRL:    res = a_srl >> shamt;
            ALU_SRA:    res = $signed(a_sra) >>> shamt;
            ALU_OR:     res = i_a | i_b;
            ALU_AND:    res = i_a & i_b;
            default:    res = i_b; // PASS_B, used by LUI
        endcase
    end

    assign o_result = i_word_op ? {{32{res[31]}}, res[31:0]} : res;

endmodule

`default_nettype wire

//--- design/branch_unit.sv
// branch condition and branch/jump target generation
`timescale 1ns/1ns
`default_nettype none

module branch_unit import rv_exec_pkg::*; (
    input  inst_class_e i_class,
    input  logic        i_pc_rel,
    input  logic [2:0]  i_funct3,
    input  xlen_t       i_rs1_value,
    input  xlen_t       i_rs2_value,
    input  xlen_t       i_imm,
    input  pc_t         i_pc,
    output logic        o_taken,
    output pc_t         o_target
);

    logic  cond;
    xlen_t jalr_sum;

    always_comb begin
        case (i_funct3)
            F3_BEQ:  cond = (i_rs1_value == i_rs2_value);
            F3_BNE:  cond = (i_rs1_value != i_rs2_value);
            F3_BLT:  cond = ($signed(i_rs1_value) < $signed(i_rs2_value));
            F3_BGE:  cond = ($signed(i_rs1_value) >= $signed(i_rs2_value));
            F3_BLTU: cond = (i_rs1_value < i_rs2_value);
            F3_BGEU: cond = (i_rs1_value >= i_rs2_value);
            default: cond = 1'b0;
        endcase
    end

    assign jalr_sum = i_rs1_value + i_imm;

    assign o_taken = (i_class == CLS_JUMP) || (i_class == CLS_BRANCH && cond);

    // JALR is the only jump not relative to the pc
    assign o_target = (i_class == CLS_JUMP && !i_pc_rel) ? {jalr_sum[31:1], 1'b0}
                                                         : i_pc + pc_t'(i_imm);

endmodule

`default_nettype wire

//--- design/exec_stage.sv
// execute stage register: writeback select, flush gating, output flops
`timescale 1ns/1ns
`default_nettype none

module exec_stage import rv_exec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_valid,
    input  logic        i_flush,
    input  inst_class_e i_class,
    input  reg_idx_t    i_rd,
    input  pc_t         i_pc,
    input  xlen_t       i_alu_result,
    input  xlen_t       i_rs2_value,
    input  logic        i_taken,
    input  pc_t         i_target,
    input  mem_size_e   i_mem_size,
    input  logic        i_mem_unsigned,
    input  logic        i_is_ecall,
    output logic        o_reg_wr_en,
    output reg_idx_t    o_reg_wr_idx,
    output xlen_t       o_reg_wr_data,
    output logic        o_valid,
    output logic        o_wr_en,
    output reg_idx_t    o_rd,
    output xlen_t       o_rd_value,
    output logic        o_redirect,
    output pc_t         o_redirect_pc,
    output logic        o_is_load,
    output logic        o_is_store,
    output xlen_t       o_mem_addr,
    output mem_size_e   o_mem_size,
    output logic        o_mem_unsigned,
    output xlen_t       o_store_data,
    output logic        o_is_ecall
);

    logic  live, redirect, is_load, is_store, mem_op;
    xlen_t wb_data, store_data;

    assign live     = i_valid && !i_flush;
    assign redirect = live && i_taken;
    assign is_load  = live && (i_class == CLS_LOAD);
    assign is_store = live && (i_class == CLS_STORE);
    assign mem_op   = is_load || is_store;

    assign wb_data = (i_class == CLS_JUMP) ? xlen_t'(i_pc) + 64'd4 : i_alu_result; // link

    // register write lands on the accepting edge
    assign o_reg_wr_en   = live && (i_class == CLS_ALU || i_class == CLS_JUMP) && (i_rd != '0);
    assign o_reg_wr_idx  = i_rd;
    assign o_reg_wr_data = wb_data;

    always_comb begin
        case (i_mem_size)
            SIZE_BYTE: store_data = {56'b0, i_rs2_value[7:0]};
            SIZE_HALF: store_data = {48'b0, i_rs2_value[15:0]};
            SIZE_WORD: store_data = {32'b0, i_rs2_value[31:0]};
            default:   store_data = i_rs2_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid    <= 1'b0;
            o_wr_en    <= 1'b0;
            o_redirect <= 1'b0;
            o_is_load  <= 1'b0;
            o_is_store <= 1'b0;
            o_is_ecall <= 1'b0;
        end else begin
            o_valid    <= live;
            o_wr_en    <= o_reg_wr_en;
            o_redirect <= redirect;
            o_is_load  <= is_load;
            o_is_store <= is_store;
            o_is_ecall <= live && i_is_ecall;
        end
    end

    // payload, zeroed whenever its strobe is low
    always_ff @(posedge clk) begin
        o_rd           <= o_reg_wr_en ? i_rd : '0;
        o_rd_value     <= o_reg_wr_en ? wb_data : '0;
        o_redirect_pc  <= redirect ? i_target : '0;
        o_mem_addr     <= mem_op ? i_alu_result : '0;
        o_mem_size     <= mem_op ? i_mem_size : SIZE_BYTE;
        o_mem_unsigned <= is_load && i_mem_unsigned;
        o_store_data   <= is_store ? store_data : '0;
    end

endmodule

`default_nettype wire

//--- design/exec_core_top.sv
// execute core top: decoder, register file, alu, branch unit and stage
`timescale 1ns/1ns
`default_nettype none

module exec_core_top import rv_exec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_valid,
    input  logic [31:0] i_inst,
    input  pc_t         i_pc,
    input  logic        i_flush,
    output logic        o_valid,
    output logic        o_wr_en,
    output reg_idx_t    o_rd,
    output xlen_t       o_rd_value,
    output logic        o_redirect,
    output pc_t         o_redirect_pc,
    output logic        o_is_load,
    output logic        o_is_store,
    output xlen_t       o_mem_addr,
    output mem_size_e   o_mem_size,
    output logic        o_mem_unsigned,
    output xlen_t       o_store_data,
    output logic        o_is_ecall
);

    reg_idx_t    rs1, rs2, rd, wr_idx;
    xlen_t       imm, rs1_value, rs2_value, alu_a, alu_b, alu_result, wr_data;
    inst_class_e inst_class;
    alu_op_e     alu_op;
    logic        word_op, use_imm, use_pc, mem_unsigned, is_ecall, taken, wr_en;
    logic [2:0]  funct3;
    mem_size_e   mem_size;
    pc_t         target;

    inst_decoder u_decoder (
        .i_inst(i_inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_class(inst_class), .o_alu_op(alu_op), .o_word_op(word_op),
        .o_use_imm(use_imm), .o_use_pc(use_pc), .o_funct3(funct3),
        .o_mem_size(mem_size), .o_mem_unsigned(mem_unsigned), .o_is_ecall(is_ecall)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .i_rs1(rs1), .i_rs2(rs2),
        .i_wr_en(wr_en), .i_wr_idx(wr_idx), .i_wr_data(wr_data),
        .o_rs1_value(rs1_value), .o_rs2_value(rs2_value)
    );

    // operand select, pc feeds AUIPC
    assign alu_a = use_pc ? xlen_t'(i_pc) : rs1_value;
    assign alu_b = use_imm ? imm : rs2_value;

    int_alu u_alu (
        .i_op(alu_op), .i_word_op(word_op), .i_a(alu_a), .i_b(alu_b), .o_result(alu_result)
    );

    branch_unit u_branch (
        .i_class(inst_class), .i_pc_rel(use_pc), .i_funct3(funct3),
        .i_rs1_value(rs1_value), .i_rs2_value(rs2_value), .i_imm(imm), .i_pc(i_pc),
        .o_taken(taken), .o_target(target)
    );

    exec_stage u_stage (
        .clk(clk), .reset(reset), .i_valid(i_valid), .i_flush(i_flush),
        .i_class(inst_class), .i_rd(rd), .i_pc(i_pc), .i_alu_result(alu_result),
        .i_rs2_value(rs2_value), .i_taken(taken), .i_target(target),
        .i_mem_size(mem_size), .i_mem_unsigned(mem_unsigned), .i_is_ecall(is_ecall),
        .o_reg_wr_en(wr_en), .o_reg_wr_idx(wr_idx), .o_reg_wr_data(wr_data),
        .o_valid(o_valid), .o_wr_en(o_wr_en), .o_rd(o_rd), .o_rd_value(o_rd_value),
        .o_redirect(o_redirect), .o_redirect_pc(o_redirect_pc),
        .o_is_load(o_is_load), .o_is_store(o_is_store), .o_mem_addr(o_mem_addr),
        .o_mem_size(o_mem_size), .o_mem_unsigned(o_mem_unsigned),
        .o_store_data(o_store_data), .o_is_ecall(o_is_ecall)
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
// testbench clock and reset source
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk; // 20 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/exec_core_assertions.sv
// concurrent output checks on the execute core, bound to its top
`timescale 1ns/1ns
`default_nettype none

module exec_core_assertions import rv_exec_pkg::*; (
    input logic     i_clk,
    input logic     i_reset,
    input logic     i_valid,
    input logic     i_wr_en,
    input reg_idx_t i_rd,
    input logic     i_redirect,
    input logic     i_is_load,
    input logic     i_is_store,
    input logic     i_is_ecall
);

    // strobes all low right after a reset cycle
    a_reset_idle: assert property (@(posedge i_clk) $past(i_reset) |->
        !(i_valid || i_wr_en || i_redirect || i_is_load || i_is_store || i_is_ecall))
        else $error("outputs active after reset");

    a_strobe_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_redirect || i_is_store || i_is_load || i_is_ecall) |-> i_valid)
        else $error("side-effect strobe without o_valid");

    a_wr_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr_en |-> (i_rd != '0))
        else $error("register write to x0");

    a_store_no_wr: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_is_store && i_wr_en))
        else $error("store with register write");

endmodule

bind exec_core_top exec_core_assertions u_assertions (
    .i_clk(clk), .i_reset(reset), .i_valid(o_valid), .i_wr_en(o_wr_en), .i_rd(o_rd),
    .i_redirect(o_redirect), .i_is_load(o_is_load), .i_is_store(o_is_store),
    .i_is_ecall(o_is_ecall)
);

`default_nettype wire

//--- verification/exec_core_tb.sv
// execute core testbench with random instructions, reference model and typed compares
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb import rv_exec_pkg::*; ;

    localparam int N_INSTS    = 62 + 200 + 160 + 480 + 100 + 24;
    localparam int TIMEOUT_NS = N_INSTS * 2 * 20 + 2000; // two cycles per instruction

    logic clk, reset, i_valid, i_flush;
    logic [31:0] i_inst;
    pc_t i_pc;
    logic o_valid, o_wr_en, o_redirect, o_is_load, o_is_store, o_mem_unsigned, o_is_ecall;
    reg_idx_t o_rd;
    xlen_t o_rd_value, o_mem_addr, o_store_data;
    pc_t o_redirect_pc;
    mem_size_e o_mem_size;

    integer seed = 41;
    int n_checks = 0;
    int n_errors = 0;
    int mark_checks = 0;
    int mark_errors = 0;
    xlen_t m_regs [32];

    // expected outputs of the instruction in flight
    logic e_valid, e_wr, e_redir, e_load, e_store, e_uns, e_ecall;
    reg_idx_t e_rd;
    xlen_t e_val, e_addr, e_sdata;
    pc_t e_rpc;
    mem_size_e e_size;

    clock_gen u_clock (.o_clk(clk), .o_reset(reset));

    exec_core_top UUT (
        .clk(clk), .reset(reset), .i_valid(i_valid), .i_inst(i_inst), .i_pc(i_pc),
        .i_flush(i_flush), .o_valid(o_valid), .o_wr_en(o_wr_en), .o_rd(o_rd),
        .o_rd_value(o_rd_value), .o_redirect(o_redirect), .o_redirect_pc(o_redirect_pc),
        .o_is_load(o_is_load), .o_is_store(o_is_store), .o_mem_addr(o_mem_addr),
        .o_mem_size(o_mem_size), .o_mem_unsigned(o_mem_unsigned),
        .o_store_data(o_store_data), .o_is_ecall(o_is_ecall)
    );

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        sext12 = {{52{v[11]}}, v};
    endfunction

    function automatic xlen_t sext32(input logic [31:0] v);
        sext32 = {{32{v[31]}}, v};
    endfunction

    // RV64I integer semantics with word forms on the low half
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input logic word,
                                      input xlen_t a, input xlen_t b);
        logic [5:0] sh;
        xlen_t r;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (word && alt) begin
                    r = $signed(sext32(a[31:0])) >>> sh;
                end else if (word) begin
                    r = {32'b0, a[31:0]} >> sh;
                end else if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        alu_ref = word ? sext32(r[31:0]) : r;
    endfunction

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input mem_size_e got, input mem_size_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic expect_idle(input logic valid);
        e_valid = valid;
        e_wr = 0;
        e_redir = 0;
        e_load = 0;
        e_store = 0;
        e_uns = 0;
        e_ecall = 0;
        e_rd = '0;
        e_val = '0;
        e_addr = '0;
        e_sdata = '0;
        e_rpc = '0;
        e_size = SIZE_BYTE;
    endtask

    task automatic expect_write(input reg_idx_t rd, input xlen_t value);
        if (rd != '0) begin
            e_wr = 1;
            e_rd = rd;
            e_val = value;
        end
    endtask

    // issue one instruction, let it retire, compare, then update the model
    task automatic issue(input logic [31:0] inst, input pc_t pc, input logic flush);
        @(posedge clk);
        i_valid <= 1'b1;
        i_inst <= inst;
        i_pc <= pc;
        i_flush <= flush;
        @(posedge clk);
        i_valid <= 1'b0;
        i_flush <= 1'b0;
        @(negedge clk);
        check_flag("o_valid", o_valid, e_valid);
        check_flag("o_wr_en", o_wr_en, e_wr);
        check_word("o_rd", xlen_t'(o_rd), xlen_t'(e_rd));
        check_word("o_rd_value", o_rd_value, e_val);
        check_flag("o_redirect", o_redirect, e_redir);
        check_pc("o_redirect_pc", o_redirect_pc, e_rpc);
        check_flag("o_is_load", o_is_load, e_load);
        check_flag("o_is_store", o_is_store, e_store);
        check_word("o_mem_addr", o_mem_addr, e_addr);
        check_size("o_mem_size", o_mem_size, e_size);
        check_flag("o_mem_unsigned", o_mem_unsigned, e_uns);
        check_word("o_store_data", o_store_data, e_sdata);
        check_flag("o_is_ecall", o_is_ecall, e_ecall);
        if (e_wr) m_regs[e_rd] = e_val;
    endtask

    // LUI then ADDIW leaves sext(x) in r
    task automatic set_reg(input reg_idx_t r, input logic [31:0] x);
        logic [31:0] up;
        up = x + 32'h800;
        expect_idle(1);
        expect_write(r, sext32({up[31:12], 12'b0}));
        issue({up[31:12], r, 7'h37}, rnd(), 0);
        expect_idle(1);
        expect_write(r, alu_ref(3'd0, 0, 1, m_regs[r], sext12(x[11:0])));
        issue({x[11:0], r, 3'd0, r, 7'h1b}, rnd(), 0);
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, n_checks - mark_checks,
                 n_errors - mark_errors);
        mark_checks = n_checks;
        mark_errors = n_errors;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish in %0d ns, stopping", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] r, r2, inst;
        logic [2:0] f3;
        logic alt;
        reg_idx_t rd, rs1, rs2;
        logic [11:0] imm;
        logic [20:0] jimm;
        logic [12:0] bimm;
        logic [31:0] a, b;
        pc_t pc;
        logic [2:0] br_f3 [6];
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        i_valid = 0;
        i_flush = 0;
        i_inst = '0;
        i_pc = '0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        @(negedge reset);

        for (int i = 1; i < 32; i++) set_reg(reg_idx_t'(i), rnd());
        for (int n = 0; n < 200; n++) begin
            r = rnd();
            r2 = rnd();
            f3 = r[4:2];
            rd = r[9:5];
            rs1 = r[14:10];
            rs2 = r[19:15];
            imm = r2[11:0];
            alt = r[20] && (f3 == 3'd0 || f3 == 3'd5);
            if (r[1]) f3 = (r[3:2] == 2'd0) ? 3'd0 : (r[3:2] == 2'd1) ? 3'd1 : 3'd5; // word ops
            expect_idle(1);
            case (r[1:0])
                2'd0: begin
                    inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
                    expect_write(rd, alu_ref(f3, alt, 0, m_regs[rs1], m_regs[rs2]));
                end
                2'd1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && f3 == 3'd5, 4'b0, imm[5:0]};
                    else alt = 0;
                    inst = {imm, rs1, f3, rd, 7'h13};
                    expect_write(rd, alu_ref(f3, alt, 0, m_regs[rs1], sext12(imm)));
                end
                2'd2: begin
                    alt = r[20] && f3 != 3'd1;
                    inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h3b};
                    expect_write(rd, alu_ref(f3, alt, 1, m_regs[rs1], m_regs[rs2]));
                end
                default: begin
                    alt = r[20] && f3 == 3'd5;
                    if (f3 != 3'd0) imm = {1'b0, alt, 5'b0, imm[4:0]};
                    inst = {imm, rs1, f3, rd, 7'h1b};
                    expect_write(rd, alu_ref(f3, alt, 1, m_regs[rs1], sext12(imm)));
                end
            endcase
            issue(inst, rnd(), 0);
        end
        end_test("test 1 alu");

        for (int n = 0; n < 40; n++) begin
            r = rnd();
            r2 = rnd();
            pc = rnd() & 32'hffff_fffc;
            rd = r[4:0];
            rs1 = r[9:5];
            imm = r2[11:0];
            expect_idle(1);
            expect_write(rd, sext32({r2[31:12], 12'b0}));
            issue({r2[31:12], rd, 7'h37}, pc, 0);
            expect_idle(1);
            expect_write(rd, {32'b0, pc} + sext32({r2[31:12], 12'b0}));
            issue({r2[31:12], rd, 7'h17}, pc, 0);
            jimm = {r[31:12], 1'b0};
            expect_idle(1);
            expect_write(rd, {32'b0, pc} + 64'd4);
            e_redir = 1;
            e_rpc = pc + {{11{jimm[20]}}, jimm};
            issue({jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'h6f}, pc, 0);
            expect_idle(1);
            e_redir = 1;
            e_rpc = (m_regs[rs1][31:0] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
            expect_write(rd, {32'b0, pc} + 64'd4);
            issue({imm, rs1, 3'd0, rd, 7'h67}, pc, 0);
        end
        end_test("test 2 upper and jumps");

        foreach (br_f3[k]) begin
            for (int rel = 0; rel < 4; rel++) begin
                for (int rep = 0; rep < 4; rep++) begin
                    a = rnd();
                    r = rnd();
                    case (rel)
                        0: b = a;
                        1: b = a + {24'b0, r[7:0]} + 1;
                        2: b = a - {24'b0, r[7:0]} - 1;
                        default: b = ~a;
                    endcase
                    set_reg(5'd5, a);
                    set_reg(5'd6, b);
                    bimm = {r[19:8], 1'b0};
                    pc = rnd() & 32'hffff_fffc;
                    expect_idle(1);
                    case (br_f3[k])
                        3'd0: e_redir = m_regs[5] == m_regs[6];
                        3'd1: e_redir = m_regs[5] != m_regs[6];
                        3'd4: e_redir = $signed(m_regs[5]) < $signed(m_regs[6]);
                        3'd5: e_redir = $signed(m_regs[5]) >= $signed(m_regs[6]);
                        3'd6: e_redir = m_regs[5] < m_regs[6];
                        default: e_redir = m_regs[5] >= m_regs[6];
                    endcase
                    e_rpc = e_redir ? pc + {{19{bimm[12]}}, bimm} : '0;
                    issue({bimm[12], bimm[10:5], 5'd6, 5'd5, br_f3[k], bimm[4:1], bimm[11],
                           7'h63}, pc, 0);
                end
            end
        end
        end_test("test 3 branches");

        for (int n = 0; n < 100; n++) begin
            r = rnd();
            rd = r[4:0];
            rs1 = r[9:5];
            rs2 = r[14:10];
            imm = r[26:15];
            f3 = r[29:27];
            expect_idle(1);
            e_addr = m_regs[rs1] + sext12(imm);
            if (r[31]) begin
                if (f3 == 3'd7) f3 = 3'd3;
                e_load = 1;
                e_size = mem_size_e'(f3[1:0]);
                e_uns = f3[2];
                inst = {imm, rs1, f3, rd, 7'h03};
            end else begin
                f3[2] = 1'b0;
                e_store = 1;
                e_size = mem_size_e'(f3[1:0]);
                case (f3[1:0])
                    2'd0: e_sdata = m_regs[rs2] & 64'hff;
                    2'd1: e_sdata = m_regs[rs2] & 64'hffff;
                    2'd2: e_sdata = m_regs[rs2] & 64'hffff_ffff;
                    default: e_sdata = m_regs[rs2];
                endcase
                inst = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
            end
            issue(inst, rnd(), 0);
        end
        end_test("test 4 loads and stores");

        for (int n = 0; n < 10; n++) begin
            r = rnd();
            rd = r[4:0] | 5'd1;
            expect_idle(0); // squashed
            issue({r[31:20], r[9:5], 3'd0, rd, 7'h13}, rnd(), 1);
            expect_idle(1); // SD rd to x0+imm reads the register back
            e_store = 1;
            e_size = SIZE_DOUBLE;
            e_addr = sext12(r[31:20]);
            e_sdata = m_regs[rd];
            issue({r[31:25], rd, 5'd0, 3'd3, r[24:20], 7'h23}, rnd(), 0);
        end
        expect_idle(1);
        e_ecall = 1;
        issue(32'h0000_0073, rnd(), 0);
        expect_idle(1);
        issue({7'h01, 5'd2, 5'd3, 3'd0, 5'd4, 7'h33}, rnd(), 0); // MUL x4
        expect_idle(1);
        issue(32'h0ff0_000f, rnd(), 0); // FENCE
        expect_idle(1);
        issue({12'h300, 5'd1, 3'b001, 5'd5, 7'h73}, rnd(), 0); // CSRRW x5
        end_test("test 5 flush and system");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/rv_exec_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/int_alu.sv
design/branch_unit.sv
design/exec_stage.sv
design/exec_core_top.sv
verification/clock_gen.sv
verification/exec_core_assertions.sv
verification/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb -f src.f &&
./obj_dir/Vexec_core_tb | tee /dev/stderr | grep -q "^test passed$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
